// ==== include/tb_dec_model.svh ====
//--------------------------------------------------------------------------
// Decoder reference model
// Bit-level decode of one word and record compare tasks for the testbench
//--------------------------------------------------------------------------
`ifndef TB_DEC_MODEL_SVH
`define TB_DEC_MODEL_SVH

// Running mismatch count
int tb_mismatch_cnt = 0;

// Expected record from raw instruction bits
function automatic dec_rec_t tb_decode(isa_word_t w);
  logic [15:0] b;
  logic [3:0]  sr;
  logic [1:0]  am;
  logic [11:0] to;
  dec_rec_t    r;
  b  = w;
  r  = '0;
  to = '0;
  r.inst_type[TYPE_TO]  = (b[15:14] != 2'b00);
  r.inst_type[TYPE_JMP] = (b[15:13] == 3'b001);
  r.inst_type[TYPE_SO]  = (b[15:13] == 3'b000);
  if (r.inst_type[TYPE_SO] && (b[9:7] != 3'(SO_IRQ)))
    r.inst_so[b[9:7]] = 1'b1;
  if (r.inst_type[TYPE_JMP])
    r.inst_jmp[b[12:10]] = 1'b1;
  if (r.inst_type[TYPE_TO])
    to[b[15:12] - 4'd4] = 1'b1;
  r.inst_mov = to[TO_MOV];
  sr = r.inst_type[TYPE_SO] ? b[3:0] : b[11:8];
  am = b[5:4];
  // Source mode and constant
  if (r.inst_type[TYPE_JMP]) begin
    r.inst_as[AM_DIR] = 1'b1;
    r.inst_sext = 16'($signed(b[9:0])) << 1;
  end else if (sr == REG_CG || (sr == REG_SR && am[1])) begin
    r.inst_as[AM_CONST] = 1'b1;
    if (sr == REG_SR)
      r.inst_sext = am[0] ? CG_8 : CG_4;
    else
      r.inst_sext = (am == 2'd0) ? CG_0 : (am == 2'd1) ? CG_1 : (am == 2'd2) ? CG_2 : CG_M1;
  end else if (am == 2'd0) r.inst_as[AM_DIR] = 1'b1;
  else if (am == 2'd2) r.inst_as[AM_INDIR] = 1'b1;
  else if (sr == REG_PC) r.inst_as[am[1] ? AM_IMM : AM_SYMB] = 1'b1;
  else if (sr == REG_SR) r.inst_as[AM_ABS] = 1'b1;
  else r.inst_as[am[1] ? AM_INDIR_I : AM_IDX] = 1'b1;
  // Destination mode
  if (r.inst_type[TYPE_TO])
    r.inst_ad[!b[7] ? AM_DIR : (b[3:0] == REG_SR) ? AM_ABS :
              (b[3:0] == REG_PC) ? AM_SYMB : AM_IDX] = 1'b1;
  r.inst_sz = 2'(r.inst_as[AM_IDX] | r.inst_as[AM_SYMB] | r.inst_as[AM_ABS] |
                 r.inst_as[AM_IMM]) +
              2'((r.inst_ad[AM_IDX] | r.inst_ad[AM_SYMB] | r.inst_ad[AM_ABS]) &
                 !r.inst_type[TYPE_SO]);
  r.inst_bw = b[6] & !r.inst_type[TYPE_JMP];
  r.inst_dest = r.inst_type[TYPE_JMP] ? 16'd1 << REG_PC :
                (r.inst_so[SO_PUSH] | r.inst_so[SO_CALL]) ? 16'd1 << REG_SP : 16'd1 << b[3:0];
  r.inst_src  = r.inst_type[TYPE_TO] ? 16'd1 << b[11:8] :
                r.inst_so[SO_RETI]   ? 16'd1 << REG_SP :
                r.inst_type[TYPE_SO] ? 16'd1 << b[3:0] : 16'h0000;
  // ALU bits
  r.inst_alu[ALU_SRC_INV] = to[TO_SUB] | to[TO_SUBC] | to[TO_CMP] | to[TO_BIC];
  r.inst_alu[ALU_INC]     = to[TO_SUB] | to[TO_CMP];
  r.inst_alu[ALU_INC_C]   = to[TO_ADDC] | to[TO_DADD] | to[TO_SUBC];
  r.inst_alu[ALU_ADD]     = |{to[TO_ADD], to[TO_ADDC], to[TO_SUB], to[TO_SUBC], to[TO_CMP],
                              r.inst_type[TYPE_JMP], r.inst_so[SO_RETI]};
  r.inst_alu[ALU_AND]     = to[TO_AND] | to[TO_BIC] | to[TO_BIT];
  r.inst_alu[ALU_OR]      = to[TO_BIS];
  r.inst_alu[ALU_XOR]     = to[TO_XOR];
  r.inst_alu[ALU_DADD]    = to[TO_DADD];
  r.inst_alu[ALU_STAT_7]  = to[TO_BIT] | to[TO_AND] | r.inst_so[SO_SXT];
  // Flags from every two-operand op except MOV, BIC and BIS
  r.inst_alu[ALU_STAT_F]  = (|(to & 12'hCFE)) | r.inst_so[SO_RRC] | r.inst_so[SO_RRA] |
                            r.inst_so[SO_SXT];
  r.inst_alu[ALU_SHIFT]   = r.inst_so[SO_RRC] | r.inst_so[SO_RRA];
  r.inst_alu[ALU_NO_WR]   = to[TO_CMP] | to[TO_BIT];
  return r;
endfunction

// One field compare
task automatic check_field(string name, logic [15:0] got, logic [15:0] exp);
  if (got !== exp) begin
    tb_mismatch_cnt++;
    $display("Mismatch %s: got %h expected %h", name, got, exp);
  end
endtask

task automatic check_rec(dec_rec_t got, dec_rec_t exp);
  check_field("inst_type", got.inst_type, exp.inst_type);
  check_field("inst_so", got.inst_so, exp.inst_so);
  check_field("inst_jmp", got.inst_jmp, exp.inst_jmp);
  check_field("inst_mov", got.inst_mov, exp.inst_mov);
  check_field("inst_bw", got.inst_bw, exp.inst_bw);
  check_field("inst_as", got.inst_as, exp.inst_as);
  check_field("inst_ad", got.inst_ad, exp.inst_ad);
  check_field("inst_sz", got.inst_sz, exp.inst_sz);
  check_field("inst_sext", got.inst_sext, exp.inst_sext);
  check_field("inst_src", got.inst_src, exp.inst_src);
  check_field("inst_dest", got.inst_dest, exp.inst_dest);
  check_field("inst_alu", got.inst_alu, exp.inst_alu);
endtask

task automatic check_count(string name, int got, int exp);
  if (got != exp) begin
    tb_mismatch_cnt++;
    $display("Mismatch %s: got %0d expected %0d", name, got, exp);
  end
endtask

`endif

// ==== bench/tb_dec.sv ====
//--------------------------------------------------------------------------
// Instruction decoder testbench
// Random and directed words through the four-phase ports, checked in
// order against a bit-level reference decode
//--------------------------------------------------------------------------
`default_nettype none

module tb_dec
  import msp430_isa_pkg::*, msp430_dec_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int N_TO        = 100;
  localparam int N_SOJ       = 100;
  localparam int N_DIR       = 16;
  localparam int N_BURST     = 200;
  localparam int TOTAL_WORDS = N_TO + N_SOJ + N_DIR + N_BURST;

  logic      mclk_decode;
  logic      puc_rst;
  logic      i_req;
  isa_word_t i_word;
  logic      i_ack;
  logic      o_ack;
  logic      o_req;
  dec_rec_t  o_dec;

  // Scoreboard state
  dec_rec_t  exp_q [$];
  int        sent_cnt  = 0;
  int        rcv_cnt   = 0;
  int        max_stall = 3;

  `include "tb_dec_model.svh"

  msp430_dec_top msp430_dec_top_inst (
    .mclk_decode (mclk_decode),
    .puc_rst     (puc_rst),
    .i_req       (i_req),
    .i_word      (i_word),
    .i_ack       (i_ack),
    .o_ack       (o_ack),
    .o_req       (o_req),
    .o_dec       (o_dec)
  );

  initial begin
    mclk_decode = 1'b0;
    forever #(CLK_PERIOD / 2) mclk_decode = ~mclk_decode;
  end

  // Run limit scaled to the number of words sent
  initial begin
    #(TOTAL_WORDS * 40 * CLK_PERIOD);
    $display("Run timed out with %0d of %0d words received", rcv_cnt, sent_cnt);
    $display("Checks failed");
    $finish;
  end

  //------------------------------------------------------------------------
  // Producer side
  //------------------------------------------------------------------------
  // Full four-phase cycle, called at clock edge plus drive delay
  task automatic send_word(isa_word_t w);
    exp_q.push_back(tb_decode(w));
    sent_cnt++;
    i_word = w;
    i_req  = 1'b1;
    do begin
      @(posedge mclk_decode);
      #2;
    end while (!o_ack);
    i_req = 1'b0;
    do begin
      @(posedge mclk_decode);
      #2;
    end while (o_ack);
  endtask

  // Wait until every word sent has come back and the port is idle,
  // then stay quiet a few cycles so a stray extra record gets counted
  task automatic drain_lanes();
    while ((rcv_cnt < sent_cnt) || o_req || i_ack) begin
      @(posedge mclk_decode);
      #2;
    end
    repeat (8) @(posedge mclk_decode);
    #2;
  endtask

  task automatic report_test(string name, int err_start);
    $display("Test %s finished, %0d errors", name, tb_mismatch_cnt - err_start);
  endtask

  //------------------------------------------------------------------------
  // Consumer with random acknowledge delay
  //------------------------------------------------------------------------
  initial begin
    int stall;
    @(negedge puc_rst);
    forever begin
      @(posedge mclk_decode);
      #2;
      if (o_req) begin
        if (exp_q.size() == 0) begin
          tb_mismatch_cnt++;
          $display("Record returned with no word outstanding");
        end else begin
          check_rec(o_dec, exp_q.pop_front());
        end
        rcv_cnt++;
        stall = $urandom_range(max_stall, 0);
        repeat (stall) @(posedge mclk_decode);
        if (stall != 0)
          #2;
        i_ack = 1'b1;
        do begin
          @(posedge mclk_decode);
          #2;
        end while (o_req);
        i_ack = 1'b0;
      end
    end
  end

  //------------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------------
  initial begin
    int          err_start;
    int          rcv_start;
    logic [15:0] w;
    void'($urandom(32'h6a49_a7b8));
    puc_rst  = 1'b1;
    i_req    = 1'b0;
    i_word   = '0;
    i_ack    = 1'b0;
    repeat (5) @(posedge mclk_decode);
    #2;
    puc_rst = 1'b0;

    // Idle after reset
    err_start = tb_mismatch_cnt;
    check_count("o_req", int'(o_req), 0);
    check_count("o_ack", int'(o_ack), 0);
    repeat (20) begin
      @(posedge mclk_decode);
      #2;
      check_count("o_req idle", int'(o_req), 0);
    end
    report_test("reset_idle", err_start);

    // Two-operand words, opcode nibble 4 to 15
    err_start = tb_mismatch_cnt;
    for (int n = 0; n < N_TO; n++) begin
      w        = 16'($urandom);
      w[15:12] = 4'(4 + $urandom_range(11, 0));
      send_word(w);
    end
    drain_lanes();
    report_test("two_operand", err_start);

    // Single-operand and jump words, alternating
    err_start = tb_mismatch_cnt;
    for (int n = 0; n < N_SOJ; n++) begin
      w        = 16'($urandom);
      w[15:13] = (n % 2 == 0) ? 3'b000 : 3'b001;
      if (n % 2 == 0)
        w[12:10] = 3'b100;
      send_word(w);
    end
    drain_lanes();
    report_test("single_op_jump", err_start);

    // R2 and R3 as source in every As value, MOV and PUSH forms
    err_start = tb_mismatch_cnt;
    for (int s = 2; s < 4; s++) begin
      for (int a = 0; a < 4; a++) begin
        send_word({4'h4, 4'(s), 1'b0, 1'b0, 2'(a), 4'h5});
        send_word({6'b000100, 3'(SO_PUSH), 1'b0, 2'(a), 4'(s)});
      end
    end
    drain_lanes();
    report_test("const_gen", err_start);

    // Burst with long consumer stalls
    err_start = tb_mismatch_cnt;
    rcv_start = rcv_cnt;
    max_stall = 15;
    for (int n = 0; n < N_BURST; n++)
      send_word(16'($urandom));
    drain_lanes();
    check_count("burst received", rcv_cnt - rcv_start, N_BURST);
    check_count("queue left", exp_q.size(), 0);
    report_test("burst", err_start);

    check_count("total received", rcv_cnt, sent_cnt);
    $display("Words sent %0d, received %0d, errors %0d", sent_cnt, rcv_cnt,
             tb_mismatch_cnt);
    if (tb_mismatch_cnt == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/msp430_dec_collect.sv ====
//--------------------------------------------------------------------------
// Decoder collector
// Drains the lanes in dispatch order and returns records on a four-phase
// req/ack port
//--------------------------------------------------------------------------
`default_nettype none

module msp430_dec_collect
  import msp430_dec_pkg::*;
(
  input  wire logic      mclk_decode,
  input  wire logic      puc_rst,
  input  wire lane_out_t i_lane_out [DEC_LANES],
  input  wire logic      i_ack,
  output logic           o_lane_release [DEC_LANES],
  output logic           o_req,
  output dec_rec_t       o_dec
);

  lane_idx_t ptr;
  logic      take;

  // Oldest lane holds a record and the port is idle
  assign take = i_lane_out[ptr].full & ~o_req & ~i_ack;

  //------------------------------------------------------------------------
  // Handshake and lane pointer
  //------------------------------------------------------------------------
  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst) begin
      o_req <= 1'b0;
      ptr   <= '0;
    end else if (take) begin
      o_req <= 1'b1;
      ptr   <= (ptr == lane_idx_t'(DEC_LANES - 1)) ? '0 : ptr + 1'b1;
    end else if (i_ack) begin
      o_req <= 1'b0;
    end
  end

  // Output holding register
  always_ff @(posedge mclk_decode) begin
    if (take)
      o_dec <= i_lane_out[ptr].rec;
  end

  // Free the lane as its record moves out
  for (genvar l = 0; l < DEC_LANES; l++) begin : g_rel
    assign o_lane_release[l] = take & (ptr == lane_idx_t'(l));

    ap_release_full: assert property (
      @(posedge mclk_decode) disable iff (puc_rst)
      o_lane_release[l] |-> i_lane_out[l].full
    ) else $error("Release toward empty lane %0d", l);
  end

  // Data must hold for the whole request phase
  ap_dec_stable: assert property (
    @(posedge mclk_decode) disable iff (puc_rst)
    o_req |=> $stable(o_dec)
  ) else $error("Decoded record changed during request");

endmodule

`default_nettype wire

// ==== rtl/msp430_dec_dispatch.sv ====
//--------------------------------------------------------------------------
// Decoder dispatcher
// Accepts words on a four-phase req/ack port and loads them round-robin
// into the decode lanes
//--------------------------------------------------------------------------
`default_nettype none

module msp430_dec_dispatch
  import msp430_isa_pkg::*, msp430_dec_pkg::*;
(
  input  wire logic       mclk_decode,
  input  wire logic       puc_rst,
  input  wire logic       i_req,
  input  wire isa_word_t  i_word,
  input  wire lane_out_t  i_lane_out [DEC_LANES],
  output logic            o_ack,
  output lane_load_t      o_lane_load [DEC_LANES]
);

  lane_idx_t ptr;
  logic      load_go;

  // New request, not yet acked, target lane empty
  assign load_go = i_req & ~o_ack & ~i_lane_out[ptr].full;

  //------------------------------------------------------------------------
  // Handshake and lane pointer
  //------------------------------------------------------------------------
  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst) begin
      o_ack <= 1'b0;
      ptr   <= '0;
    end else if (load_go) begin
      o_ack <= 1'b1;
      // Wrap also for lane counts that are not a power of two
      ptr   <= (ptr == lane_idx_t'(DEC_LANES - 1)) ? '0 : ptr + 1'b1;
    end else if (!i_req) begin
      // Return to zero phase
      o_ack <= 1'b0;
    end
  end

  // Word fans out to all lanes, strobe only to the one at the pointer
  for (genvar l = 0; l < DEC_LANES; l++) begin : g_load
    assign o_lane_load[l] = '{load: load_go & (ptr == lane_idx_t'(l)), word: i_word};

    ap_load_empty: assert property (
      @(posedge mclk_decode) disable iff (puc_rst)
      o_lane_load[l].load |-> !i_lane_out[l].full
    ) else $error("Load strobe toward full lane %0d", l);
  end

  // Ack only answers a request seen one edge earlier
  ap_ack_after_req: assert property (
    @(posedge mclk_decode) disable iff (puc_rst)
    $rose(o_ack) |-> $past(i_req)
  ) else $error("Ack raised without request");

endmodule

`default_nettype wire

// ==== rtl/msp430_dec_lane.sv ====
//--------------------------------------------------------------------------
// Decode lane
// Decodes one instruction word and holds the record until the collector
// releases it
//--------------------------------------------------------------------------
`default_nettype none

module msp430_dec_lane
  import msp430_isa_pkg::*, msp430_dec_pkg::*;
(
  input  wire logic       mclk_decode,
  input  wire logic       puc_rst,
  input  wire lane_load_t i_load,
  input  wire logic       i_release,
  output lane_out_t       o_lane
);

  isa_word_t   ir;
  logic [15:0] to_16;
  logic [11:0] to_nxt;
  logic [3:0]  src_reg;
  logic [1:0]  as_fld;
  logic        is_const;
  logic [15:0] cg_val;
  logic        src_ext;
  logic        dst_ext;
  dec_rec_t    rec_nxt;
  dec_rec_t    rec_q;
  logic        full_q;

  assign ir    = i_load.word;
  assign to_16 = 16'd1 << ir.to.opcode;

  //------------------------------------------------------------------------
  // Combinational decode
  //------------------------------------------------------------------------
  always_comb begin
    rec_nxt  = '0;
    is_const = 1'b0;
    cg_val   = CG_0;

    // Instruction type
    rec_nxt.inst_type[TYPE_TO]  = (ir.to.opcode[3:2] != 2'b00);
    rec_nxt.inst_type[TYPE_JMP] = (ir.jmp.prefix == 3'b001);
    rec_nxt.inst_type[TYPE_SO]  = (ir.jmp.prefix == 3'b000);

    // Opcode one-hots, no interrupt source in this decoder
    if (rec_nxt.inst_type[TYPE_SO])
      rec_nxt.inst_so = 8'd1 << ir.so.op;
    rec_nxt.inst_so[SO_IRQ] = 1'b0;
    if (rec_nxt.inst_type[TYPE_JMP])
      rec_nxt.inst_jmp = 8'd1 << ir.jmp.cond;
    to_nxt = rec_nxt.inst_type[TYPE_TO] ? to_16[15:4] : 12'h000;
    rec_nxt.inst_mov = to_nxt[TO_MOV];

    // As field sits at bits 5:4 in both operand formats
    as_fld = ir.to.as;

    // Source register field depends on format
    if (rec_nxt.inst_type[TYPE_SO]) begin
      src_reg = ir.so.reg_id;
    end else begin
      src_reg = ir.to.src;
    end

    // Source addressing mode
    if (rec_nxt.inst_type[TYPE_JMP]) begin
      rec_nxt.inst_as[AM_DIR] = 1'b1;
    end else if (src_reg == REG_CG) begin
      // R3 is a pure constant generator
      is_const = 1'b1;
      case (as_fld)
        2'b00:   cg_val = CG_0;
        2'b01:   cg_val = CG_1;
        2'b10:   cg_val = CG_2;
        default: cg_val = CG_M1;
      endcase
    end else if ((src_reg == REG_SR) && as_fld[1]) begin
      // R2 indirect modes give 4 and 8
      is_const = 1'b1;
      cg_val   = as_fld[0] ? CG_8 : CG_4;
    end else begin
      case (as_fld)
        2'b00: rec_nxt.inst_as[AM_DIR]   = 1'b1;
        2'b10: rec_nxt.inst_as[AM_INDIR] = 1'b1;
        2'b01: begin
          if (src_reg == REG_SR)      rec_nxt.inst_as[AM_ABS]  = 1'b1;
          else if (src_reg == REG_PC) rec_nxt.inst_as[AM_SYMB] = 1'b1;
          else                        rec_nxt.inst_as[AM_IDX]  = 1'b1;
        end
        default: begin
          if (src_reg == REG_PC) rec_nxt.inst_as[AM_IMM]     = 1'b1;
          else                   rec_nxt.inst_as[AM_INDIR_I] = 1'b1;
        end
      endcase
    end
    rec_nxt.inst_as[AM_CONST] = is_const;

    // Destination addressing mode, two-operand only
    if (rec_nxt.inst_type[TYPE_TO]) begin
      if (!ir.to.ad)              rec_nxt.inst_ad[AM_DIR]  = 1'b1;
      else if (ir.to.dst == REG_SR) rec_nxt.inst_ad[AM_ABS]  = 1'b1;
      else if (ir.to.dst == REG_PC) rec_nxt.inst_ad[AM_SYMB] = 1'b1;
      else                        rec_nxt.inst_ad[AM_IDX]  = 1'b1;
    end

    // Extension words
    src_ext = rec_nxt.inst_as[AM_IDX] | rec_nxt.inst_as[AM_SYMB] |
              rec_nxt.inst_as[AM_ABS] | rec_nxt.inst_as[AM_IMM];
    dst_ext = (rec_nxt.inst_ad[AM_IDX] | rec_nxt.inst_ad[AM_SYMB] |
               rec_nxt.inst_ad[AM_ABS]) & ~rec_nxt.inst_type[TYPE_SO];
    rec_nxt.inst_sz = {1'b0, src_ext} + {1'b0, dst_ext};

    // Constant value, or jump offset in bytes
    if (is_const)
      rec_nxt.inst_sext = cg_val;
    else if (rec_nxt.inst_type[TYPE_JMP])
      rec_nxt.inst_sext = {{5{ir.jmp.offset[9]}}, ir.jmp.offset, 1'b0};

    rec_nxt.inst_bw = ir.to.bw & ~rec_nxt.inst_type[TYPE_JMP];

    // Register one-hots
    if (rec_nxt.inst_type[TYPE_JMP])
      rec_nxt.inst_dest = 16'd1 << REG_PC;
    else if (rec_nxt.inst_so[SO_PUSH] | rec_nxt.inst_so[SO_CALL])
      rec_nxt.inst_dest = 16'd1 << REG_SP;
    else
      rec_nxt.inst_dest = 16'd1 << ir.to.dst;

    if (rec_nxt.inst_type[TYPE_TO])
      rec_nxt.inst_src = 16'd1 << ir.to.src;
    else if (rec_nxt.inst_so[SO_RETI])
      rec_nxt.inst_src = 16'd1 << REG_SP;
    else if (rec_nxt.inst_type[TYPE_SO])
      rec_nxt.inst_src = 16'd1 << ir.so.reg_id;

    // ALU control
    rec_nxt.inst_alu[ALU_SRC_INV] = to_nxt[TO_SUB] | to_nxt[TO_SUBC] |
                                    to_nxt[TO_CMP] | to_nxt[TO_BIC];
    rec_nxt.inst_alu[ALU_INC]     = to_nxt[TO_SUB] | to_nxt[TO_CMP];
    rec_nxt.inst_alu[ALU_INC_C]   = to_nxt[TO_ADDC] | to_nxt[TO_DADD] | to_nxt[TO_SUBC];
    rec_nxt.inst_alu[ALU_ADD]     = to_nxt[TO_ADD] | to_nxt[TO_ADDC] | to_nxt[TO_SUB] |
                                    to_nxt[TO_SUBC] | to_nxt[TO_CMP] |
                                    rec_nxt.inst_type[TYPE_JMP] | rec_nxt.inst_so[SO_RETI];
    rec_nxt.inst_alu[ALU_AND]     = to_nxt[TO_AND] | to_nxt[TO_BIC] | to_nxt[TO_BIT];
    rec_nxt.inst_alu[ALU_OR]      = to_nxt[TO_BIS];
    rec_nxt.inst_alu[ALU_XOR]     = to_nxt[TO_XOR];
    rec_nxt.inst_alu[ALU_DADD]    = to_nxt[TO_DADD];
    rec_nxt.inst_alu[ALU_STAT_7]  = to_nxt[TO_BIT] | to_nxt[TO_AND] | rec_nxt.inst_so[SO_SXT];
    rec_nxt.inst_alu[ALU_STAT_F]  = to_nxt[TO_ADD] | to_nxt[TO_ADDC] | to_nxt[TO_SUB] |
                                    to_nxt[TO_SUBC] | to_nxt[TO_CMP] | to_nxt[TO_DADD] |
                                    to_nxt[TO_BIT] | to_nxt[TO_XOR] | to_nxt[TO_AND] |
                                    rec_nxt.inst_so[SO_RRC] | rec_nxt.inst_so[SO_RRA] |
                                    rec_nxt.inst_so[SO_SXT];
    rec_nxt.inst_alu[ALU_SHIFT]   = rec_nxt.inst_so[SO_RRC] | rec_nxt.inst_so[SO_RRA];
    rec_nxt.inst_alu[ALU_NO_WR]   = to_nxt[TO_CMP] | to_nxt[TO_BIT];
  end

  //------------------------------------------------------------------------
  // Record and occupancy
  //------------------------------------------------------------------------
  always_ff @(posedge mclk_decode) begin
    if (i_load.load)
      rec_q <= rec_nxt;
  end

  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst)
      full_q <= 1'b0;
    else if (i_load.load)
      full_q <= 1'b1;
    else if (i_release)
      full_q <= 1'b0;
  end

  assign o_lane = '{full: full_q, rec: rec_q};

  // Dispatcher must wait for the collector to drain this lane
  ap_no_overwrite: assert property (
    @(posedge mclk_decode) disable iff (puc_rst)
    i_load.load |-> !full_q
  ) else $error("Lane loaded while still full");

endmodule

`default_nettype wire

// ==== rtl/msp430_dec_pkg.sv ====
//--------------------------------------------------------------------------
// Decoder datapath types
// Decoded record, lane count and the lane transfer structs
//--------------------------------------------------------------------------
`default_nettype none

package msp430_dec_pkg;
  import msp430_isa_pkg::*;

  // Lanes in flight, 1 to 4 supported
  localparam int DEC_LANES = 2;
  localparam int LANE_W    = (DEC_LANES > 1) ? $clog2(DEC_LANES) : 1;

  typedef logic [LANE_W-1:0] lane_idx_t;

  // One decoded instruction
  typedef struct packed {
    logic [2:0]  inst_type;
    logic [7:0]  inst_so;
    logic [7:0]  inst_jmp;
    logic        inst_mov;
    logic        inst_bw;
    logic [7:0]  inst_as;
    logic [7:0]  inst_ad;
    logic [1:0]  inst_sz;
    logic [15:0] inst_sext;
    logic [15:0] inst_src;
    logic [15:0] inst_dest;
    logic [11:0] inst_alu;
  } dec_rec_t;

  // Dispatcher to lane
  typedef struct packed {
    logic      load;
    isa_word_t word;
  } lane_load_t;

  // Lane to collector and dispatcher
  typedef struct packed {
    logic     full;
    dec_rec_t rec;
  } lane_out_t;

endpackage

`default_nettype wire

// ==== rtl/msp430_dec_top.sv ====
//--------------------------------------------------------------------------
// Instruction decoder top
// Dispatcher, parallel decode lanes and in-order collector
//--------------------------------------------------------------------------
`default_nettype none

module msp430_dec_top
  import msp430_isa_pkg::*, msp430_dec_pkg::*;
(
  input  wire logic      mclk_decode,
  input  wire logic      puc_rst,
  input  wire logic      i_req,
  input  wire isa_word_t i_word,
  input  wire logic      i_ack,
  output logic           o_ack,
  output logic           o_req,
  output dec_rec_t       o_dec
);

  lane_load_t lane_load    [DEC_LANES];
  lane_out_t  lane_out     [DEC_LANES];
  logic       lane_release [DEC_LANES];

  msp430_dec_dispatch msp430_dec_dispatch_inst (
    .mclk_decode (mclk_decode),
    .puc_rst     (puc_rst),
    .i_req       (i_req),
    .i_word      (i_word),
    .i_lane_out  (lane_out),
    .o_ack       (o_ack),
    .o_lane_load (lane_load)
  );

  // Decode lanes
  for (genvar l = 0; l < DEC_LANES; l++) begin : g_lane
    msp430_dec_lane msp430_dec_lane_inst (
      .mclk_decode (mclk_decode),
      .puc_rst     (puc_rst),
      .i_load      (lane_load[l]),
      .i_release   (lane_release[l]),
      .o_lane      (lane_out[l])
    );
  end

  msp430_dec_collect msp430_dec_collect_inst (
    .mclk_decode    (mclk_decode),
    .puc_rst        (puc_rst),
    .i_lane_out     (lane_out),
    .i_ack          (i_ack),
    .o_lane_release (lane_release),
    .o_req          (o_req),
    .o_dec          (o_dec)
  );

endmodule

`default_nettype wire

// ==== rtl/msp430_isa_pkg.sv ====
//--------------------------------------------------------------------------
// MSP430 instruction set definitions
// Views of one instruction word, bit positions of the one-hot decoded
// fields, constant-generator values and special register numbers
//--------------------------------------------------------------------------
`default_nettype none

package msp430_isa_pkg;

  // Two-operand format
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] src;
    logic       ad;
    logic       bw;
    logic [1:0] as;
    logic [3:0] dst;
  } isa_to_t;

  // Single-operand format, register field doubles as source and destination
  typedef struct packed {
    logic [5:0] prefix;
    logic [2:0] op;
    logic       bw;
    logic [1:0] as;
    logic [3:0] reg_id;
  } isa_so_t;

  // Conditional jump, PC relative word offset
  typedef struct packed {
    logic [2:0] prefix;
    logic [2:0] cond;
    logic [9:0] offset;
  } isa_jmp_t;

  typedef union packed {
    isa_to_t  to;
    isa_so_t  so;
    isa_jmp_t jmp;
  } isa_word_t;

  // Instruction type one-hot
  localparam int TYPE_SO = 0, TYPE_JMP = 1, TYPE_TO = 2;

  // Single-operand one-hot, IRQ kept for encoding compatibility
  localparam int SO_RRC  = 0, SO_SWPB = 1, SO_RRA  = 2, SO_SXT = 3,
                 SO_PUSH = 4, SO_CALL = 5, SO_RETI = 6, SO_IRQ = 7;

  // Two-operand one-hot, opcode nibble 4 is bit 0
  localparam int TO_MOV = 0, TO_ADD  = 1,  TO_ADDC = 2,  TO_SUBC = 3,
                 TO_SUB = 4, TO_CMP  = 5,  TO_DADD = 6,  TO_BIT  = 7,
                 TO_BIC = 8, TO_BIS  = 9,  TO_XOR  = 10, TO_AND  = 11;

  // Addressing mode one-hot
  localparam int AM_DIR  = 0, AM_IDX = 1, AM_INDIR = 2, AM_INDIR_I = 3,
                 AM_SYMB = 4, AM_IMM = 5, AM_ABS   = 6, AM_CONST   = 7;

  // ALU control bits
  localparam int ALU_SRC_INV = 0, ALU_INC    = 1, ALU_INC_C  = 2,  ALU_ADD   = 3,
                 ALU_AND     = 4, ALU_OR     = 5, ALU_XOR    = 6,  ALU_DADD  = 7,
                 ALU_STAT_7  = 8, ALU_STAT_F = 9, ALU_SHIFT  = 10, ALU_NO_WR = 11;

  // Constant generator outputs
  localparam logic [15:0] CG_4  = 16'h0004;
  localparam logic [15:0] CG_8  = 16'h0008;
  localparam logic [15:0] CG_0  = 16'h0000;
  localparam logic [15:0] CG_1  = 16'h0001;
  localparam logic [15:0] CG_2  = 16'h0002;
  localparam logic [15:0] CG_M1 = 16'hffff;

  // Special registers
  localparam logic [3:0] REG_PC = 4'd0;
  localparam logic [3:0] REG_SP = 4'd1;
  localparam logic [3:0] REG_SR = 4'd2;
  localparam logic [3:0] REG_CG = 4'd3;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/msp430_isa_pkg.sv
rtl/msp430_dec_pkg.sv
rtl/msp430_dec_dispatch.sv
rtl/msp430_dec_lane.sv
rtl/msp430_dec_collect.sv
rtl/msp430_dec_top.sv
bench/tb_dec.sv
